// File: include/cnn_defines.svh
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// ============================================================
// datapath widths
// ============================================================

// pixel, weight and pooled output word
`define CNN_PIX_W 8

// dot product accumulator, 3 products of 16 bits plus growth
`define CNN_ACC_W 20

// ============================================================
// kernel and activation
// ============================================================

`define CNN_TAPS 3

// leaky slope of 1/8 for negative sums
`define CNN_LRELU_SHIFT 3

// ============================================================
// output side
// ============================================================

// power of two, pointers wrap naturally
`define CNN_OUT_DEPTH 4

`endif

// File: rtl/cnn_pkg.sv
`include "cnn_defines.svh"

package cnn_pkg;

  // ============================================================
  // stream word tags and data types
  // ============================================================

  typedef enum logic [1:0] {
    OP_WEIGHT  = 2'd0,
    OP_PIXEL   = 2'd1,
    OP_ROW_END = 2'd2,
    OP_NOP     = 2'd3
  } cnn_op_e;

  typedef logic signed [`CNN_PIX_W-1:0] pix_t;
  typedef logic signed [`CNN_ACC_W-1:0] acc_t;

  // ============================================================
  // handshake state machines
  // ============================================================

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_ACK,      // ack high, waiting for req to drop
    RX_WAIT_LOW  // ack low again
  } rx_state_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_REQ,          // req high, waiting for ack
    TX_WAIT_ACK_LOW
  } tx_state_e;

endpackage

// File: rtl/stream_rx.sv
`timescale 1ns/1ps

module stream_rx import cnn_pkg::*; (
  input  logic    aclk,
  input  logic    i_rst,
  // four-phase input port
  input  logic    i_in_req,
  input  cnn_op_e i_in_op,
  input  pix_t    i_in_data,
  output logic    o_in_ack,
  // link to the engine
  output logic    o_rx_valid,
  output cnn_op_e o_rx_op,
  output pix_t    o_rx_data,
  input  logic    i_eng_ready
);

  rx_state_e state;
  logic      take;

  // a new word is only sampled while the engine can move the previous one
  assign take = (state == RX_IDLE) && i_in_req && i_eng_ready;

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      state      <= RX_IDLE;
      o_in_ack   <= 1'b0;
      o_rx_valid <= 1'b0;
    end else begin
      if (o_rx_valid && i_eng_ready) begin
        o_rx_valid <= 1'b0;               // word taken by engine
      end
      case (state)
        RX_IDLE: begin
          if (take) begin
            o_in_ack   <= 1'b1;
            o_rx_valid <= (i_in_op != OP_NOP); // nop is acked, not forwarded
            state      <= RX_ACK;
          end
        end
        RX_ACK: begin
          if (!i_in_req) begin
            o_in_ack <= 1'b0;
            state    <= RX_WAIT_LOW;
          end
        end
        RX_WAIT_LOW: begin
          state <= RX_IDLE;               // one quiet cycle before next word
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      o_rx_op   <= i_in_op;
      o_rx_data <= i_in_data;
    end
  end

endmodule

// File: rtl/conv_row_engine.sv
`timescale 1ns/1ps

`include "cnn_defines.svh"

module conv_row_engine import cnn_pkg::*; (
  input  logic    aclk,
  input  logic    i_rst,
  // from the receiver
  input  logic    i_rx_valid,
  input  cnn_op_e i_rx_op,
  input  pix_t    i_rx_data,
  output logic    o_eng_ready,
  // to activation and pooling, row end beats carry no sum
  output logic    o_conv_valid,
  output acc_t    o_conv_sum,
  output logic    o_conv_row_end,
  input  logic    i_pool_ready
);

  localparam int IDX_W = $clog2(`CNN_TAPS);

  pix_t             w [`CNN_TAPS];
  pix_t             win [`CNN_TAPS-1];   // last two pixels, highest index newest
  pix_t             taps [`CNN_TAPS];
  logic [IDX_W-1:0] w_idx;
  logic [IDX_W-1:0] fill;               // pixels of this row in the window
  logic             accept;
  logic             win_full;
  acc_t             next_sum;

  // output register stalls the whole engine
  assign o_eng_ready = !o_conv_valid || i_pool_ready;
  assign accept      = i_rx_valid && o_eng_ready;
  assign win_full    = (fill == IDX_W'(`CNN_TAPS - 1));

  // ============================================================
  // dot product over the window plus the incoming pixel
  // ============================================================

  always_comb begin
    for (int k = 0; k < `CNN_TAPS - 1; k++) begin
      taps[k] = win[k];
    end
    taps[`CNN_TAPS-1] = i_rx_data;
    next_sum = '0;
    for (int k = 0; k < `CNN_TAPS; k++) begin
      next_sum = next_sum + acc_t'(w[k]) * acc_t'(taps[k]);
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      for (int k = 0; k < `CNN_TAPS; k++) begin
        w[k] <= '0;
      end
      w_idx          <= '0;
      fill           <= '0;
      o_conv_valid   <= 1'b0;
      o_conv_row_end <= 1'b0;
    end else begin
      if (o_conv_valid && i_pool_ready) begin
        o_conv_valid   <= 1'b0;
        o_conv_row_end <= 1'b0;
      end
      if (accept) begin
        case (i_rx_op)
          OP_WEIGHT: begin
            w[w_idx] <= i_rx_data;
            w_idx    <= (w_idx == IDX_W'(`CNN_TAPS - 1)) ? '0 : w_idx + 1'b1;
          end
          OP_PIXEL: begin
            if (win_full) begin
              o_conv_valid <= 1'b1;
            end else begin
              fill <= fill + 1'b1;
            end
          end
          OP_ROW_END: begin
            fill           <= '0;         // next row starts empty
            o_conv_valid   <= 1'b1;
            o_conv_row_end <= 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (accept && (i_rx_op == OP_PIXEL)) begin
      for (int k = 0; k < `CNN_TAPS - 2; k++) begin
        win[k] <= win[k+1];
      end
      win[`CNN_TAPS-2] <= i_rx_data;
      if (win_full) begin
        o_conv_sum <= next_sum;
      end
    end
  end

endmodule

// File: rtl/lrelu_maxpool.sv
`timescale 1ns/1ps

`include "cnn_defines.svh"

module lrelu_maxpool import cnn_pkg::*; (
  input  logic aclk,
  input  logic i_rst,
  // from the engine
  input  logic i_conv_valid,
  input  acc_t i_conv_sum,
  input  logic i_conv_row_end,
  output logic o_pool_ready,
  // to the output FIFO
  output logic o_pool_valid,
  output pix_t o_pool_data,
  output logic o_pool_last,
  input  logic i_tx_ready
);

  localparam acc_t SAT_HI = acc_t'((1 << (`CNN_PIX_W - 1)) - 1);
  localparam acc_t SAT_LO = -SAT_HI - acc_t'(1);

  acc_t leaky;
  pix_t act;
  pix_t first_val;      // first result of a pair
  pix_t hold_val;       // pooled word waiting to learn its last flag
  pix_t pair_max;
  pix_t hold_next;
  logic have_first;
  logic hold_valid;
  logic out_free;
  logic split_end;
  logic work;
  logic emit;
  logic emit_last;
  logic load_first;
  logic load_hold;

  // leaky relu then clamp to a pixel
  assign leaky    = i_conv_sum[`CNN_ACC_W-1] ? (i_conv_sum >>> `CNN_LRELU_SHIFT) : i_conv_sum;
  assign act      = (leaky > SAT_HI) ? pix_t'(SAT_HI) :
                    (leaky < SAT_LO) ? pix_t'(SAT_LO) : pix_t'(leaky);
  assign pair_max = (act > first_val) ? act : first_val;

  // a row end behind a lone result takes two passes, the beat stays put on the first
  assign out_free     = !o_pool_valid || i_tx_ready;
  assign split_end    = i_conv_valid && i_conv_row_end && have_first;
  assign o_pool_ready = out_free && !split_end;
  assign work         = i_conv_valid && out_free;

  always_comb begin
    emit       = 1'b0;
    emit_last  = 1'b0;
    load_first = 1'b0;
    load_hold  = 1'b0;
    hold_next  = pair_max;
    if (work) begin
      if (i_conv_row_end) begin
        emit = hold_valid;
        if (have_first) begin
          load_hold = 1'b1;           // lone result becomes a pooled word
          hold_next = first_val;
        end else begin
          emit_last = 1'b1;
        end
      end else if (!have_first) begin
        load_first = 1'b1;
      end else begin
        load_hold = 1'b1;
        emit      = hold_valid;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      have_first   <= 1'b0;
      hold_valid   <= 1'b0;
      o_pool_valid <= 1'b0;
    end else begin
      if (o_pool_valid && i_tx_ready) begin
        o_pool_valid <= 1'b0;
      end
      if (emit) begin
        o_pool_valid <= 1'b1;
      end
      if (load_first) begin
        have_first <= 1'b1;
      end else if (load_hold) begin
        have_first <= 1'b0;
      end
      if (load_hold) begin
        hold_valid <= 1'b1;
      end else if (emit && emit_last) begin
        hold_valid <= 1'b0;           // row flushed
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (load_first) begin
      first_val <= act;
    end
    if (load_hold) begin
      hold_val <= hold_next;
    end
    if (emit) begin
      o_pool_data <= hold_val;
      o_pool_last <= emit_last;
    end
  end

endmodule

// File: rtl/stream_tx.sv
`timescale 1ns/1ps

`include "cnn_defines.svh"

module stream_tx import cnn_pkg::*; (
  input  logic aclk,
  input  logic i_rst,
  // from pooling
  input  logic i_pool_valid,
  input  pix_t i_pool_data,
  input  logic i_pool_last,
  output logic o_tx_ready,
  // four-phase output port
  output logic o_out_req,
  output pix_t o_out_data,
  output logic o_out_last,
  input  logic i_out_ack
);

  localparam int PTR_W = $clog2(`CNN_OUT_DEPTH);
  localparam int CNT_W = $clog2(`CNN_OUT_DEPTH + 1);

  pix_t             mem_data [`CNN_OUT_DEPTH];
  logic             mem_last [`CNN_OUT_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  tx_state_e        state;
  logic             push;
  logic             pop;
  logic             launch;

  assign o_tx_ready = (count != CNT_W'(`CNN_OUT_DEPTH));
  assign push       = i_pool_valid && o_tx_ready;
  assign launch     = (state == TX_IDLE) && (count != '0);
  // head leaves only once the receiver has let go of ack
  assign pop        = (state == TX_WAIT_ACK_LOW) && !i_out_ack;

  // ============================================================
  // FIFO storage
  // ============================================================

  always_ff @(posedge aclk) begin
    if (push) begin
      mem_data[wr_ptr] <= i_pool_data;
      mem_last[wr_ptr] <= i_pool_last;
    end
    if (launch) begin
      o_out_data <= mem_data[rd_ptr];   // held for the whole exchange
      o_out_last <= mem_last[rd_ptr];
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      state     <= TX_IDLE;
      o_out_req <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      case (state)
        TX_IDLE: begin
          if (launch) begin
            o_out_req <= 1'b1;
            state     <= TX_REQ;
          end
        end
        TX_REQ: begin
          if (i_out_ack) begin
            o_out_req <= 1'b0;
            state     <= TX_WAIT_ACK_LOW;
          end
        end
        TX_WAIT_ACK_LOW: begin
          if (!i_out_ack) begin
            state <= TX_IDLE;
          end
        end
        default: begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

endmodule

// File: rtl/cnn_row_top.sv
`timescale 1ns/1ps

module cnn_row_top import cnn_pkg::*; (
  input  logic    aclk,
  input  logic    i_rst,
  input  logic    i_in_req,
  input  cnn_op_e i_in_op,
  input  pix_t    i_in_data,
  output logic    o_in_ack,
  output logic    o_out_req,
  output pix_t    o_out_data,
  output logic    o_out_last,
  input  logic    i_out_ack
);

  // receiver to engine
  logic    rx_valid;
  cnn_op_e rx_op;
  pix_t    rx_data;
  logic    eng_ready;
  // engine to pooling
  logic    conv_valid;
  acc_t    conv_sum;
  logic    conv_row_end;
  logic    pool_ready;
  // pooling to output FIFO
  logic    pool_valid;
  pix_t    pool_data;
  logic    pool_last;
  logic    tx_ready;

  stream_rx u_rx (
    .aclk        (aclk),
    .i_rst       (i_rst),
    .i_in_req    (i_in_req),
    .i_in_op     (i_in_op),
    .i_in_data   (i_in_data),
    .o_in_ack    (o_in_ack),
    .o_rx_valid  (rx_valid),
    .o_rx_op     (rx_op),
    .o_rx_data   (rx_data),
    .i_eng_ready (eng_ready)
  );

  conv_row_engine u_engine (
    .aclk           (aclk),
    .i_rst          (i_rst),
    .i_rx_valid     (rx_valid),
    .i_rx_op        (rx_op),
    .i_rx_data      (rx_data),
    .o_eng_ready    (eng_ready),
    .o_conv_valid   (conv_valid),
    .o_conv_sum     (conv_sum),
    .o_conv_row_end (conv_row_end),
    .i_pool_ready   (pool_ready)
  );

  lrelu_maxpool u_pool (
    .aclk           (aclk),
    .i_rst          (i_rst),
    .i_conv_valid   (conv_valid),
    .i_conv_sum     (conv_sum),
    .i_conv_row_end (conv_row_end),
    .o_pool_ready   (pool_ready),
    .o_pool_valid   (pool_valid),
    .o_pool_data    (pool_data),
    .o_pool_last    (pool_last),
    .i_tx_ready     (tx_ready)
  );

  stream_tx u_tx (
    .aclk         (aclk),
    .i_rst        (i_rst),
    .i_pool_valid (pool_valid),
    .i_pool_data  (pool_data),
    .i_pool_last  (pool_last),
    .o_tx_ready   (tx_ready),
    .o_out_req    (o_out_req),
    .o_out_data   (o_out_data),
    .o_out_last   (o_out_last),
    .i_out_ack    (i_out_ack)
  );

endmodule

// File: testbench/cnn_row_chk.sv
`timescale 1ns/1ps

module cnn_row_chk import cnn_pkg::*; (
  input logic aclk,
  input logic i_rst,
  input logic i_in_req,
  input logic o_in_ack,
  input logic o_out_req,
  input pix_t o_out_data,
  input logic o_out_last,
  input logic i_out_ack
);

  int fail_count = 0;

  // ============================================================
  // input port
  // ============================================================

  in_ack_rise_a: assert property (@(posedge aclk) disable iff (i_rst)
    $rose(o_in_ack) |-> $past(i_in_req))  // req seen on the edge that raised ack
    else begin
      fail_count = fail_count + 1;
      $error("o_in_ack rose while i_in_req was low");
    end

  in_ack_hold_a: assert property (@(posedge aclk) disable iff (i_rst)
    o_in_ack && i_in_req |=> o_in_ack)  // ack held until req drops
    else begin
      fail_count = fail_count + 1;
      $error("o_in_ack fell while i_in_req was still high");
    end

  // ============================================================
  // output port
  // ============================================================

  out_stable_a: assert property (@(posedge aclk) disable iff (i_rst)
    o_out_req && $past(o_out_req) |-> $stable(o_out_data) && $stable(o_out_last))
    else begin
      fail_count = fail_count + 1;
      $error("o_out_data or o_out_last changed while o_out_req was high");
    end

  out_req_hold_a: assert property (@(posedge aclk) disable iff (i_rst)
    o_out_req && !i_out_ack |=> o_out_req)
    else begin
      fail_count = fail_count + 1;
      $error("o_out_req fell before i_out_ack rose");
    end

  reset_idle_a: assert property (@(posedge aclk)
    $fell(i_rst) |-> !o_in_ack && !o_out_req)
    else begin
      fail_count = fail_count + 1;
      $error("handshake outputs not low after reset");
    end

endmodule

bind cnn_row_top cnn_row_chk u_chk (
  .aclk       (aclk),
  .i_rst      (i_rst),
  .i_in_req   (i_in_req),
  .o_in_ack   (o_in_ack),
  .o_out_req  (o_out_req),
  .o_out_data (o_out_data),
  .o_out_last (o_out_last),
  .i_out_ack  (i_out_ack)
);

// File: testbench/cnn_row_tb.sv
`timescale 1ns/1ps

`include "cnn_defines.svh"

module cnn_row_tb import cnn_pkg::*; ();

  localparam int MAX_WORDS    = 256;
  localparam int CYCLES_PER_W = 40;
  localparam int QUIET_CYCLES = 20;
  localparam int STALL_CYCLES = 4;

  logic    aclk;
  logic    i_rst;
  logic    i_in_req;
  cnn_op_e i_in_op;
  pix_t    i_in_data;
  logic    o_in_ack;
  logic    o_out_req;
  pix_t    o_out_data;
  logic    o_out_last;
  logic    i_out_ack;

  logic [15:0] vec_mem [MAX_WORDS];   // kind, op or last, data
  cnn_op_e     stim_op_q [$];
  pix_t        stim_data_q [$];
  pix_t        exp_data_q [$];
  logic        exp_last_q [$];
  logic [31:0] lcg_state = 32'h457c;
  int          cycle_limit = 0;
  int          cycles = 0;

  cnn_row_top u_dut (
    .aclk       (aclk),
    .i_rst      (i_rst),
    .i_in_req   (i_in_req),
    .i_in_op    (i_in_op),
    .i_in_data  (i_in_data),
    .o_in_ack   (o_in_ack),
    .o_out_req  (o_out_req),
    .o_out_data (o_out_data),
    .o_out_last (o_out_last),
    .i_out_ack  (i_out_ack)
  );

  // ============================================================
  // clock and watchdog
  // ============================================================

  initial aclk = 1'b0;
  always #50 aclk = ~aclk;

  always @(negedge aclk) begin
    cycles = cycles + 1;
    if (u_dut.u_chk.fail_count != 0) begin
      $display("handshake checker reported %0d assertion failures", u_dut.u_chk.fail_count);
      stop_with_failure();
    end else if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, output words still missing", cycles);
      stop_with_failure();
    end
  end

  task automatic stop_with_failure();
    $display("Verification failed");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ============================================================
  // data file
  // ============================================================

  task automatic load_vectors();
    logic [15:0] entry;
    cnn_op_e     op;
    int          row_pixels;
    row_pixels = 0;
    foreach (vec_mem[i]) begin
      vec_mem[i] = '0;                  // unused tail reads as padding
    end
    $readmemh("testbench/cnn_row_testdata.txt", vec_mem);
    foreach (vec_mem[i]) begin
      entry = vec_mem[i];
      case (entry[15:12])
        4'h0: begin
        end
        4'h1: begin
          op = cnn_op_e'(entry[9:8]);
          stim_op_q.push_back(op);
          stim_data_q.push_back(pix_t'(entry[`CNN_PIX_W-1:0]));
          if (op == OP_PIXEL) begin
            row_pixels = row_pixels + 1;
          end else if (op == OP_ROW_END) begin
            if (row_pixels < `CNN_TAPS + 1) begin
              $display("data file has a row of only %0d pixels", row_pixels);
              stop_with_failure();
            end
            row_pixels = 0;
          end
        end
        4'h2: begin
          exp_data_q.push_back(pix_t'(entry[`CNN_PIX_W-1:0]));
          exp_last_q.push_back(entry[8]);
        end
        default: begin
          $display("data file entry %0d has an unknown kind", i);
          stop_with_failure();
        end
      endcase
    end
    if (stim_op_q.size() == 0 || exp_data_q.size() == 0) begin
      $display("no input or expected words found in the data file");
      stop_with_failure();
    end
  endtask

  // ============================================================
  // compare tasks
  // ============================================================

  task automatic compare_pix(input string name, input int idx, input pix_t got, input pix_t exp);
    if (got !== exp) begin
      $display("** Error: %s word %0d got 0x%h expected 0x%h", name, idx, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic compare_last(input string name, input int idx, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s word %0d got 0x%h expected 0x%h", name, idx, got, exp);
      stop_with_failure();
    end
  endtask

  // ============================================================
  // four-phase drivers
  // ============================================================

  task automatic wait_in_ack(input logic level);
    do begin
      @(posedge aclk);
      #1;
    end while (o_in_ack !== level);
  endtask

  task automatic wait_out_req(input logic level);
    do begin
      @(posedge aclk);
      #1;
    end while (o_out_req !== level);
  endtask

  task automatic wait_input_stall();
    int stalled;
    stalled = 0;
    while (stalled < STALL_CYCLES) begin
      @(negedge aclk);
      if (i_in_req && !o_in_ack) begin
        stalled = stalled + 1;          // req pending without ack
      end else begin
        stalled = 0;
      end
    end
  endtask

  task automatic drive_stimulus();
    for (int i = 0; i < stim_op_q.size(); i++) begin
      i_in_op   = stim_op_q[i];
      i_in_data = stim_data_q[i];
      i_in_req  = 1'b1;
      wait_in_ack(1'b1);
      i_in_req = 1'b0;
      wait_in_ack(1'b0);                // data may change from here
    end
  endtask

  task automatic collect_outputs();
    int   gap;
    pix_t got_data;
    logic got_last;
    wait_input_stall();                 // FIFO full, back-pressure up to the input
    for (int n = 0; n < exp_data_q.size(); n++) begin
      wait_out_req(1'b1);
      got_data = o_out_data;
      got_last = o_out_last;
      compare_pix("o_out_data", n, got_data, exp_data_q[n]);
      compare_last("o_out_last", n, got_last, exp_last_q[n]);
      gap = int'((next_rand() >> 16) % 32'd6);  // 0 to 5 cycles of back-pressure
      repeat (gap) begin
        @(posedge aclk);
        #1;
      end
      i_out_ack = 1'b1;
      wait_out_req(1'b0);
      i_out_ack = 1'b0;
    end
  endtask

  task automatic check_quiet_output();
    repeat (QUIET_CYCLES) begin
      @(posedge aclk);
      #1;
      if (o_out_req) begin
        $display("an output word arrived after the last expected word");
        stop_with_failure();
      end
    end
  endtask

  // ============================================================
  // main sequence
  // ============================================================

  initial begin
    i_rst     = 1'b1;
    i_in_req  = 1'b0;
    i_in_op   = OP_NOP;
    i_in_data = '0;
    i_out_ack = 1'b0;
    load_vectors();
    cycle_limit = CYCLES_PER_W * (stim_op_q.size() + exp_data_q.size());
    repeat (2) @(posedge aclk);
    #1;
    i_rst = 1'b0;
    fork
      drive_stimulus();
      collect_outputs();
    join
    check_quiet_output();
    if (u_dut.u_chk.fail_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("handshake checker reported assertion failures");
      stop_with_failure();
    end
  end

endmodule

// File: testbench/cnn_row_testdata.txt
// one hex word per entry: kind nibble, op or last nibble, data byte
// kind 1 input word (op 0 weight, 1 pixel, 2 row end, 3 nop), kind 2 expected output (last flag)
// weights 1 2 1, row 1..6
1001 1002 1001
1101 1102 1103 1104 1105 1106 1200
// odd result count, last result saturates high
110A 1114 111E 1128 1132 1200
// weights -1 -2 -1, leaky slope on negative sums
10FF 10FE 10FF
1108 1110 1118 1120 1128 1130 1200
// sums -8 and -13, shift rounds down
1101 1102 1103 1105 1200
// weights 127, saturation both ways
107F 107F 107F
1180 1180 1180 117F 117F 117F 1200
// nops between rows, inside the weight load and inside the row
13EE
1000 13A5 1001 1000
1105 1300 11F0 110A 13FF 11FB 1107 1103 1109 1200
// weights 1 1 1, long row for back-pressure
1001 1001 1001
1103 11F9 110C 1105 11EC 1109 111E 11FE 1104 110F 11F7 1106 1200
117F 117F 117F 117F 1200
// expected pooled words
200C 2114
2078 217F
20F8 21F0
21FF
2080 217F
200A 2007 2103
200A 20FF 2025 2020 210C
217F

// File: filelist.f
+incdir+include
rtl/cnn_pkg.sv
rtl/stream_rx.sv
rtl/conv_row_engine.sv
rtl/lrelu_maxpool.sv
rtl/stream_tx.sv
rtl/cnn_row_top.sv
testbench/cnn_row_chk.sv
testbench/cnn_row_tb.sv

// File: run.sh
#!/bin/sh
# build and run the row convolution testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module cnn_row_tb -f filelist.f -o cnn_row_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/cnn_row_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
